//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // ==========================================================
  // basic word and register types
  // ==========================================================

  // data and address word
  typedef logic [31:0] word_t;

  // register number, r15 is the pc
  typedef logic [3:0] reg_idx_t;

  // cpsr condition flags
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // ==========================================================
  // instruction field encodings
  // ==========================================================

  // data-processing opcodes, arm encoding order
  typedef enum logic [3:0] {
    AND, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
    TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
  } alu_op_t;

  // condition field, bits 31:28
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } cond_t;

  // shift type, bits 6:5
  typedef enum logic [1:0] {
    LSL, LSR, ASR, ROR
  } shift_t;

  // ==========================================================
  // control encodings
  // ==========================================================

  // one cycle per state
  typedef enum logic [2:0] {
    FETCH, DECODE, EXECUTE, MEM, LOAD_WB, HALT
  } cpu_state_t;

  // alu operand b source
  typedef enum logic [1:0] {
    SHIFTER, BRANCH_OFFSET, LOAD_OFFSET
  } b_src_t;

  // register writeback source
  typedef enum logic [2:0] {
    NONE, ALU_TO_RD, READ_DATA_TO_RD, ALU_TO_PC, ALU_TO_PC_LINK
  } wb_src_t;

  // memory address source
  typedef enum logic {
    PC, ALU_LATCH
  } addr_src_t;

endpackage

`default_nettype wire

//--- cpu/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_pkg::alu_op_t alu_op,
  input  cpu_pkg::word_t   op_a,
  input  cpu_pkg::word_t   op_b,
  input  logic             carry_in,
  input  logic             shift_carry,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags_out
);
  import cpu_pkg::*;

  // shared adder inputs
  word_t       add_x;
  word_t       add_y;
  logic        add_cin;
  logic        arith;
  logic [32:0] sum;
  logic        overflow;

  // ==========================================================
  // adder operand selection
  // ==========================================================

  // subtract as x + ~y + 1, reverse ops swap x and y
  always_comb begin
    add_x   = op_a;
    add_y   = op_b;
    add_cin = 1'b0;
    arith   = 1'b1;
    unique case (alu_op)
      ADD, CMN: add_cin = 1'b0;
      ADC:      add_cin = carry_in;
      SUB, CMP: begin
        add_y   = ~op_b;
        add_cin = 1'b1;
      end
      SBC: begin
        add_y   = ~op_b;
        add_cin = carry_in;
      end
      RSB: begin
        add_x   = op_b;
        add_y   = ~op_a;
        add_cin = 1'b1;
      end
      RSC: begin
        add_x   = op_b;
        add_y   = ~op_a;
        add_cin = carry_in;
      end
      default: arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_cin};
  // same input signs, different result sign
  assign overflow = (add_x[31] == add_y[31]) && (sum[31] != add_x[31]);

  // ==========================================================
  // result and flags
  // ==========================================================
  always_comb begin
    unique case (alu_op)
      AND, TST: result = op_a & op_b;
      EOR, TEQ: result = op_a ^ op_b;
      ORR:      result = op_a | op_b;
      MOV:      result = op_b;
      BIC:      result = op_a & ~op_b;
      MVN:      result = ~op_b;
      default:  result = sum[31:0];
    endcase
  end

  // carry here means no borrow on subtract
  assign flags_out.n = result[31];
  assign flags_out.z = (result == 32'd0);
  assign flags_out.c = arith ? sum[32] : shift_carry;
  assign flags_out.v = arith && overflow;

endmodule

`default_nettype wire

//--- cpu/barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
  input  logic            use_imm,
  input  logic [7:0]      imm8,
  input  logic [3:0]      imm_rotate,
  input  cpu_pkg::word_t  rm_data,
  input  cpu_pkg::shift_t shift_type,
  input  logic [4:0]      shift_imm,
  input  logic            carry_in,
  output cpu_pkg::word_t  operand2,
  output logic            shift_carry
);
  import cpu_pkg::*;

  logic [4:0]  rot_amt;
  logic [63:0] imm_rot;
  // one extra bit catches the carry out
  logic [32:0] lsl_ext;
  logic [32:0] lsr_ext;
  logic [32:0] asr_ext;
  logic [63:0] ror_ext;

  // immediate rotates right by twice the field
  assign rot_amt = {imm_rotate, 1'b0};
  assign imm_rot = {24'd0, imm8, 24'd0, imm8} >> rot_amt;

  assign lsl_ext = {1'b0, rm_data} << shift_imm;
  assign lsr_ext = {rm_data, 1'b0} >> shift_imm;
  assign asr_ext = $signed({rm_data, 1'b0}) >>> shift_imm;
  assign ror_ext = {rm_data, rm_data} >> shift_imm;

  always_comb begin
    if (use_imm) begin
      operand2    = imm_rot[31:0];
      shift_carry = (rot_amt == 5'd0) ? carry_in : imm_rot[31];
    end else begin
      unique case (shift_type)
        LSL: begin
          // lsl #0 passes rm and carry through
          operand2    = lsl_ext[31:0];
          shift_carry = (shift_imm == 5'd0) ? carry_in : lsl_ext[32];
        end
        LSR: begin
          // lsr #0 encodes lsr #32
          operand2    = (shift_imm == 5'd0) ? 32'd0 : lsr_ext[32:1];
          shift_carry = (shift_imm == 5'd0) ? rm_data[31] : lsr_ext[0];
        end
        ASR: begin
          // asr #0 encodes asr #32, sign fill
          operand2    = (shift_imm == 5'd0) ? {32{rm_data[31]}} : asr_ext[32:1];
          shift_carry = (shift_imm == 5'd0) ? rm_data[31] : asr_ext[0];
        end
        default: begin
          // ror #0 is rrx, old carry into bit 31
          operand2    = (shift_imm == 5'd0) ? {carry_in, rm_data[31:1]} : ror_ext[31:0];
          shift_carry = (shift_imm == 5'd0) ? rm_data[0] : ror_ext[31];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cpu/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic          clk,
  input  logic          reset,
  output cpu_pkg::word_t addr,
  output logic          read_en,
  output logic          write_en,
  output cpu_pkg::word_t wdata,
  input  cpu_pkg::word_t rdata,
  output logic          halted
);
  import cpu_pkg::*;

  // decoded fields from control
  reg_idx_t  rn_idx;
  reg_idx_t  rm_idx;
  reg_idx_t  rd_idx;
  alu_op_t   alu_op;
  logic      set_flags;
  b_src_t    b_src;
  shift_t    shift_type;
  logic [4:0] shift_imm;
  logic [3:0] imm_rotate;
  logic [7:0] imm8;
  logic      use_imm;
  word_t     branch_offset;
  word_t     load_offset;
  wb_src_t   wb_src;
  addr_src_t addr_src;
  logic      pc_incr;
  logic      latch_addr;

  // datapath
  word_t  rn_data;
  word_t  rm_data;
  word_t  rd_data;
  word_t  pc;
  flags_t flags;
  word_t  operand2;
  logic   shift_carry;
  word_t  op_b;
  word_t  alu_result;
  flags_t alu_flags;
  flags_t flags_in;
  logic   logic_op;
  word_t  addr_latch;

  cpu_control u_control (
    .clk          (clk),
    .reset        (reset),
    .rdata        (rdata),
    .flags        (flags),
    .rn_idx       (rn_idx),
    .rm_idx       (rm_idx),
    .rd_idx       (rd_idx),
    .alu_op       (alu_op),
    .set_flags    (set_flags),
    .b_src        (b_src),
    .shift_type   (shift_type),
    .shift_imm    (shift_imm),
    .imm_rotate   (imm_rotate),
    .imm8         (imm8),
    .use_imm      (use_imm),
    .branch_offset(branch_offset),
    .load_offset  (load_offset),
    .offset_sub   (),
    .wb_src       (wb_src),
    .addr_src     (addr_src),
    .pc_incr      (pc_incr),
    .latch_addr   (latch_addr),
    .read_en      (read_en),
    .write_en     (write_en),
    .halted       (halted)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .reset     (reset),
    .rn_idx    (rn_idx),
    .rm_idx    (rm_idx),
    .rd_idx    (rd_idx),
    .rn_data   (rn_data),
    .rm_data   (rm_data),
    .rd_data   (rd_data),
    .wb_src    (wb_src),
    .alu_result(alu_result),
    .rdata     (rdata),
    .pc_incr   (pc_incr),
    .set_flags (set_flags),
    .flags_in  (flags_in),
    .flags     (flags),
    .pc        (pc)
  );

  barrel_shifter u_shifter (
    .use_imm    (use_imm),
    .imm8       (imm8),
    .imm_rotate (imm_rotate),
    .rm_data    (rm_data),
    .shift_type (shift_type),
    .shift_imm  (shift_imm),
    .carry_in   (flags.c),
    .operand2   (operand2),
    .shift_carry(shift_carry)
  );

  alu u_alu (
    .alu_op     (alu_op),
    .op_a       (rn_data),
    .op_b       (op_b),
    .carry_in   (flags.c),
    .shift_carry(shift_carry),
    .result     (alu_result),
    .flags_out  (alu_flags)
  );

  // ==========================================================
  // operand b mux
  // ==========================================================
  always_comb begin
    unique case (b_src)
      BRANCH_OFFSET: op_b = branch_offset;
      LOAD_OFFSET:   op_b = load_offset;
      default:       op_b = operand2;
    endcase
  end

  // logic ops leave v as it was
  assign logic_op = alu_op inside {AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN};

  always_comb begin
    flags_in = alu_flags;
    if (logic_op) begin
      flags_in.v = flags.v;
    end
  end

  // ==========================================================
  // memory address and write data
  // ==========================================================

  // ldr/str address computed in execute, used in mem
  always_ff @(posedge clk) begin
    if (latch_addr) begin
      addr_latch <= alu_result;
    end
  end

  assign addr  = (addr_src == ALU_LATCH) ? addr_latch : pc;
  // str data comes from rd
  assign wdata = rd_data;

endmodule

`default_nettype wire

//--- cpu/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
  input  logic               clk,
  input  logic               reset,
  input  cpu_pkg::word_t     rdata,
  input  cpu_pkg::flags_t    flags,
  output cpu_pkg::reg_idx_t  rn_idx,
  output cpu_pkg::reg_idx_t  rm_idx,
  output cpu_pkg::reg_idx_t  rd_idx,
  output cpu_pkg::alu_op_t   alu_op,
  output logic               set_flags,
  output cpu_pkg::b_src_t    b_src,
  output cpu_pkg::shift_t    shift_type,
  output logic [4:0]         shift_imm,
  output logic [3:0]         imm_rotate,
  output logic [7:0]         imm8,
  output logic               use_imm,
  output cpu_pkg::word_t     branch_offset,
  output cpu_pkg::word_t     load_offset,
  output logic               offset_sub,
  output cpu_pkg::wb_src_t   wb_src,
  output cpu_pkg::addr_src_t addr_src,
  output logic               pc_incr,
  output logic               latch_addr,
  output logic               read_en,
  output logic               write_en,
  output logic               halted
);
  import cpu_pkg::*;

  word_t      ir;
  cpu_state_t state;
  cpu_state_t next_state;

  // instruction class and fields
  logic    is_dp;
  logic    is_mem;
  logic    is_branch;
  logic    is_load;
  logic    test_op;
  logic    cond_ok;
  logic    swi_taken;
  alu_op_t dp_op;

  // ==========================================================
  // decode
  // ==========================================================

  // 00x data processing, 010 ldr/str imm, 101 branch
  assign is_dp     = (ir[27:26] == 2'b00);
  assign is_mem    = (ir[27:25] == 3'b010);
  assign is_branch = (ir[27:25] == 3'b101);
  assign is_load   = ir[20];
  assign dp_op     = alu_op_t'(ir[24:21]);
  // compare ops only touch flags
  assign test_op   = dp_op inside {TST, TEQ, CMP, CMN};

  // arm condition table
  function automatic logic cond_pass(input cond_t cond, input flags_t f);
    logic pass;
    unique case (cond)
      EQ:      pass = f.z;
      NE:      pass = !f.z;
      CS:      pass = f.c;
      CC:      pass = !f.c;
      MI:      pass = f.n;
      PL:      pass = !f.n;
      VS:      pass = f.v;
      VC:      pass = !f.v;
      HI:      pass = f.c && !f.z;
      LS:      pass = !f.c || f.z;
      GE:      pass = (f.n == f.v);
      LT:      pass = (f.n != f.v);
      GT:      pass = !f.z && (f.n == f.v);
      LE:      pass = f.z || (f.n != f.v);
      AL:      pass = 1'b1;
      default: pass = 1'b0;
    endcase
    return pass;
  endfunction

  assign cond_ok = cond_pass(cond_t'(ir[31:28]), flags);

  // swi halts only when its own condition passes
  assign swi_taken = (rdata[27:24] == 4'b1111) && cond_pass(cond_t'(rdata[31:28]), flags);

  // branches read r15 as base at pc+8
  assign rn_idx = is_branch ? 4'd15 : ir[19:16];
  assign rm_idx = ir[3:0];
  assign rd_idx = ir[15:12];

  // operand 2 fields straight from ir
  assign use_imm    = ir[25];
  assign imm8       = ir[7:0];
  assign imm_rotate = ir[11:8];
  assign shift_imm  = ir[11:7];
  assign shift_type = shift_t'(ir[6:5]);

  // offsets
  assign branch_offset = {{6{ir[23]}}, ir[23:0], 2'b00};
  assign load_offset   = {20'd0, ir[11:0]};
  // u bit clear means subtract
  assign offset_sub    = is_mem && !ir[23];

  always_comb begin
    if (is_mem) begin
      alu_op = offset_sub ? SUB : ADD;
    end else if (is_branch) begin
      alu_op = ADD;
    end else begin
      alu_op = dp_op;
    end
  end

  assign b_src = is_branch ? BRANCH_OFFSET : (is_mem ? LOAD_OFFSET : SHIFTER);

  // ==========================================================
  // state-dependent strobes
  // ==========================================================
  assign read_en    = (state == FETCH) || (state == MEM && is_load);
  assign write_en   = (state == MEM) && !is_load;
  assign pc_incr    = (state == DECODE);
  assign addr_src   = (state == MEM) ? ALU_LATCH : PC;
  assign latch_addr = (state == EXECUTE) && is_mem && cond_ok;
  assign halted     = (state == HALT);
  assign set_flags  = (state == EXECUTE) && is_dp && cond_ok && (ir[20] || test_op);

  always_comb begin
    wb_src = NONE;
    if (state == EXECUTE && cond_ok) begin
      if (is_dp && !test_op) begin
        wb_src = ALU_TO_RD;
      end else if (is_branch) begin
        // bit 24 is the link bit
        wb_src = ir[24] ? ALU_TO_PC_LINK : ALU_TO_PC;
      end
    end else if (state == LOAD_WB) begin
      wb_src = READ_DATA_TO_RD;
    end
  end

  // ==========================================================
  // state machine
  // ==========================================================
  always_comb begin
    unique case (state)
      FETCH:   next_state = DECODE;
      // swi seen on the fetched word itself
      DECODE:  next_state = swi_taken ? HALT : EXECUTE;
      EXECUTE: next_state = (is_mem && cond_ok) ? MEM : FETCH;
      MEM:     next_state = is_load ? LOAD_WB : FETCH;
      LOAD_WB: next_state = FETCH;
      default: next_state = HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH;
      ir    <= '0;
    end else begin
      state <= next_state;
      if (state == DECODE) begin
        ir <= rdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- cpu/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_idx_t rn_idx,
  input  cpu_pkg::reg_idx_t rm_idx,
  input  cpu_pkg::reg_idx_t rd_idx,
  output cpu_pkg::word_t    rn_data,
  output cpu_pkg::word_t    rm_data,
  output cpu_pkg::word_t    rd_data,
  input  cpu_pkg::wb_src_t  wb_src,
  input  cpu_pkg::word_t    alu_result,
  input  cpu_pkg::word_t    rdata,
  input  logic              pc_incr,
  input  logic              set_flags,
  input  cpu_pkg::flags_t   flags_in,
  output cpu_pkg::flags_t   flags,
  output cpu_pkg::word_t    pc
);
  import cpu_pkg::*;

  word_t regs [16];

  assign pc = regs[15];

  // pc already +4 after decode, reads of r15 see +8
  assign rn_data = regs[rn_idx] + ((rn_idx == 4'd15) ? 32'd4 : 32'd0);
  assign rm_data = regs[rm_idx] + ((rm_idx == 4'd15) ? 32'd4 : 32'd0);
  assign rd_data = regs[rd_idx] + ((rd_idx == 4'd15) ? 32'd4 : 32'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      regs  <= '{default: '0};
      flags <= '0;
    end else begin
      if (pc_incr) begin
        regs[15] <= regs[15] + 32'd4;
      end
      // rd of 15 here is a jump
      unique case (wb_src)
        ALU_TO_RD:       regs[rd_idx] <= alu_result;
        READ_DATA_TO_RD: regs[rd_idx] <= rdata;
        ALU_TO_PC:       regs[15] <= alu_result;
        ALU_TO_PC_LINK: begin
          regs[15] <= alu_result;
          // stored pc is the bl address + 4
          regs[14] <= regs[15];
        end
        default: ;
      endcase
      if (set_flags) begin
        flags <= flags_in;
      end
    end
  end

endmodule

`default_nettype wire

//--- flist.f
common/cpu_pkg.sv
cpu/barrel_shifter.sv
cpu/alu.sv
cpu/reg_file.sv
cpu/cpu_control.sv
cpu/cpu.sv
testbench/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module cpu_tb -o cpu_sim

# the simulator exits nonzero on failure, the log search decides
./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0

//--- testbench/cpu_patterns.txt
# tag address word: P = program word, E = expected final memory word
# addresses are byte addresses in hex
P 000 E3A0AC02
P 004 E3A014FF
P 008 E3A02005
P 00C E0813002
P 010 E58A3000
P 014 E2424007
P 018 E58A4004
P 01C E2625C01
P 020 E58A5008
P 024 E203600F
P 028 E58A600C
P 02C E22370FF
P 030 E58A7010
P 034 E3828030
P 038 E58A8014
P 03C E3C39001
P 040 E58A9018
P 044 E1E0B002
P 048 E58AB01C
P 04C E3A0C106
P 050 E1B0302C
P 054 E2A34000
P 058 E58A4020
P 05C E1B0504C
P 060 E58A5024
P 064 E1B0626C
P 068 E2A67000
P 06C E58A7028
P 070 E1B0806C
P 074 E2A89000
P 078 E58A902C
P 07C E1B0B08C
P 080 E2ABB000
P 084 E58AB030
P 088 E08A3E2C
P 08C E58A3034
P 090 E3A01000
P 094 E3520005
P 098 03811001
P 09C 13811002
P 0A0 23811004
P 0A4 33811008
P 0A8 43811010
P 0AC 53811020
P 0B0 63811040
P 0B4 73811080
P 0B8 83811C01
P 0BC 93811C02
P 0C0 A3811C04
P 0C4 B3811C08
P 0C8 C3811C10
P 0CC D3811C20
P 0D0 E58A1038
P 0D4 E3A04000
P 0D8 E3E03102
P 0DC E3730001
P 0E0 03844001
P 0E4 13844002
P 0E8 23844004
P 0EC 33844008
P 0F0 43844010
P 0F4 53844020
P 0F8 63844040
P 0FC 73844080
P 100 83844C01
P 104 93844C02
P 108 A3844C04
P 10C B3844C08
P 110 C3844C10
P 114 D3844C20
P 118 E58A403C
P 11C E3120004
P 120 13A05011
P 124 E3320005
P 128 03A06022
P 12C 13A06033
P 130 E58A5040
P 134 E58A6044
P 138 E3A030AB
P 13C E58A3080
P 140 E3A080CD
P 144 E58A8084
P 148 E28A7C01
P 14C E5174080
P 150 E59A5084
P 154 E58A4048
P 158 E58A504C
P 15C EA000000
P 160 E58AA0C0
P 164 EB000003
P 168 E58AE050
P 16C E58A9054
P 170 EF000000
P 174 E58AA0C4
P 178 E3A0905A
P 17C E1A0F00E
E 200 FF000005
E 204 FFFFFFFE
E 208 000000FB
E 20C 00000005
E 210 FF0000FA
E 214 00000035
E 218 FF000004
E 21C FFFFFFFA
E 220 00000001
E 224 FFFFFFFF
E 228 18000000
E 22C 40000001
E 230 00000003
E 234 00000208
E 238 000026A5
E 23C 0000165A
E 240 00000011
E 244 00000022
E 248 000000AB
E 24C 000000CD
E 250 00000168
E 254 0000005A
E 280 000000AB
E 284 000000CD
E 2C0 00000000
E 2C4 00000000

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  // dut side
  logic  clk;
  logic  reset;
  word_t addr;
  logic  read_en;
  logic  write_en;
  word_t wdata;
  word_t rdata;
  logic  halted;

  // memory model indexed by byte address bits 9:2
  word_t mem [256];

  // expected final memory words from the patterns file
  word_t exp_addr [$];
  word_t exp_word [$];

  int prog_words;
  int cycles;
  int limit;

  cpu uut (
    .clk     (clk),
    .reset   (reset),
    .addr    (addr),
    .read_en (read_en),
    .write_en(write_en),
    .wdata   (wdata),
    .rdata   (rdata),
    .halted  (halted)
  );

  // ==========================================================
  // reporting
  // ==========================================================

  // prints the reason and ends the run
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %08h, actual %08h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // ==========================================================
  // clock, memory, timeout
  // ==========================================================

  // 40 ns period
  always #20 clk = ~clk;

  // read data follows read_en by one edge
  always @(posedge clk) begin
    if (read_en && write_en) begin
      stop_run("read_en and write_en were high in the same cycle");
    end
    if (read_en) begin
      rdata <= mem[addr[9:2]];
    end
    // stores land on the write_en edge
    if (write_en) begin
      if (halted) begin
        stop_run("memory write seen while the core was halted");
      end
      mem[addr[9:2]] = wdata;
    end
  end

  // counted on the falling edge away from dut updates
  always @(negedge clk) begin
    if (!reset) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
        stop_run("timeout, the core never reached the halt instruction");
      end
    end
  end

  // tag P marks a program word and tag E an expected final word
  task automatic load_patterns();
    int         fd;
    int         n;
    logic [7:0] tag;
    word_t      a;
    word_t      w;
    string      line;
    fd = $fopen("testbench/cpu_patterns.txt", "r");
    if (fd == 0) begin
      stop_run("could not open testbench/cpu_patterns.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%c %h %h", tag, a, w);
      if (n == 3 && tag == "P") begin
        mem[a[9:2]] = w;
        prog_words = prog_words + 1;
      end else if (n == 3 && tag == "E") begin
        exp_addr.push_back(a);
        exp_word.push_back(w);
      end
    end
    $fclose(fd);
  endtask

  // ==========================================================
  // main sequence
  // ==========================================================
  initial begin
    clk        = 1'b0;
    reset      <= 1'b1;
    rdata      <= '0;
    cycles     = 0;
    prog_words = 0;
    limit      = 1000;
    // untouched addresses read back zero
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
    load_patterns();
    if (prog_words == 0 || exp_addr.size() == 0) begin
      stop_run("patterns file holds no program or no expected words");
    end
    limit = 5 * prog_words + 20;

    // reset for 4 cycles
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // run until the swi halts the core
    do begin
      @(negedge clk);
    end while (!halted);

    // idle cycles where any write trips the memory model
    repeat (5) @(negedge clk);
    if (!halted) begin
      stop_run("halted dropped after the core had stopped");
    end

    foreach (exp_addr[i]) begin
      check_word($sformatf("mem[0x%03h]", exp_addr[i]), exp_word[i], mem[exp_addr[i][9:2]]);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
